/* src/matrix_ctrl_pkg.sv */
/*
 * Shared constants and types for the LED matrix command decoder.
 * Default panel geometry, brightness plane count, FSM states and command opcodes.
 */
package matrix_ctrl_pkg;

    // default panel geometry of 32 rows by 64 columns
    localparam int ROW_BITS_DEF = 5;
    localparam int COL_BITS_DEF = 6;

    // brightness bit planes
    localparam int BRIGHTNESS_LEVELS = 6;

    typedef enum logic [2:0] {
        IDLE,
        READ_BRIGHTNESS,
        BLANK,
        FILL,
        PIXEL
    } ctrl_state_e;

    // ascii command bytes
    typedef enum logic [7:0] {
        OP_BRIGHT_CLEAR = 8'h30,  // "0"
        OP_BRIGHT_1     = 8'h31,
        OP_BRIGHT_2     = 8'h32,
        OP_BRIGHT_3     = 8'h33,
        OP_BRIGHT_4     = 8'h34,
        OP_BRIGHT_5     = 8'h35,
        OP_BRIGHT_6     = 8'h36,
        OP_BRIGHT_SET   = 8'h39,  // "9"
        OP_BLUE_ON      = 8'h42,  // "B"
        OP_FILL         = 8'h46,  // "F"
        OP_GREEN_ON     = 8'h47,  // "G"
        OP_PIXEL        = 8'h50,  // "P"
        OP_RED_ON       = 8'h52,  // "R"
        OP_BRIGHT_LOAD  = 8'h54,  // "T"
        OP_BLANK        = 8'h5a,  // "Z"
        OP_BLUE_OFF     = 8'h62,  // "b"
        OP_GREEN_OFF    = 8'h67,  // "g"
        OP_RED_OFF      = 8'h72   // "r"
    } cmd_opcode_e;

endpackage

/* src/cmd_dispatch.sv */
/*
 * Byte accept and command FSM. Decodes opcodes in IDLE, owns the colour enables,
 * starts the write engines and routes the active engine onto the RAM port.
 */
`timescale 1ns/10ps

module cmd_dispatch #(
    parameter int ROW_BITS = matrix_ctrl_pkg::ROW_BITS_DEF,
    parameter int COL_BITS = matrix_ctrl_pkg::COL_BITS_DEF
) (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic [7:0]                 data_rx,
    input  logic                       data_ready_n,
    input  logic [ROW_BITS+COL_BITS:0] sweep_addr,
    input  logic [7:0]                 sweep_data,
    input  logic                       sweep_write_en,
    input  logic                       sweep_done,
    input  logic [ROW_BITS+COL_BITS:0] pixel_addr,
    input  logic [7:0]                 pixel_data,
    input  logic                       pixel_write_en,
    input  logic                       pixel_done,
    output logic                       ready_for_data,
    output logic                       busy,
    output logic                       byte_valid,
    output logic [7:0]                 byte_data,
    output logic                       digit_valid,
    output logic [2:0]                 rgb_enable,
    output logic                       brightness_load,
    output logic                       sweep_start,
    output logic                       sweep_fill,
    output logic                       pixel_start,
    output logic [ROW_BITS+COL_BITS:0] ram_address,
    output logic [7:0]                 ram_data_out,
    output logic                       ram_write_enable
);

    import matrix_ctrl_pkg::*;

    localparam int ADDR_BITS = ROW_BITS + COL_BITS + 1;

    ctrl_state_e state;
    cmd_opcode_e opcode;
    logic        cmd_accept;
    logic        engine_done;

    // a byte is taken on any edge where the sender strobes and we are ready
    assign byte_valid = ~data_ready_n & ready_for_data;
    assign byte_data  = data_rx;
    assign opcode     = cmd_opcode_e'(data_rx);
    assign cmd_accept = byte_valid && (state == IDLE);

    // engines latch their start on the opcode's own accept edge
    assign sweep_start = cmd_accept && ((opcode == OP_BLANK) || (opcode == OP_FILL));
    assign sweep_fill  = (opcode == OP_FILL);
    assign pixel_start = cmd_accept && (opcode == OP_PIXEL);

    assign brightness_load = (state == READ_BRIGHTNESS);
    assign digit_valid     = byte_valid && ((state == IDLE) || (state == READ_BRIGHTNESS));

    // RAM port follows whichever engine owns the current state
    always_comb begin
        ram_address      = {ADDR_BITS{1'b0}};
        ram_data_out     = 8'd0;
        ram_write_enable = 1'b0;
        engine_done      = 1'b0;
        case (state)
            READ_BRIGHTNESS: begin
                engine_done = byte_valid;
            end
            BLANK, FILL: begin
                ram_address      = sweep_addr;
                ram_data_out     = sweep_data;
                ram_write_enable = sweep_write_en;
                engine_done      = sweep_done;
            end
            PIXEL: begin
                ram_address      = pixel_addr;
                ram_data_out     = pixel_data;
                ram_write_enable = pixel_write_en;
                engine_done      = pixel_done;
            end
            default: begin
            end
        endcase
    end

    // hold the sender off while RAM writes are in flight
    assign ready_for_data = ~ram_write_enable;
    assign busy           = (state != IDLE) && !engine_done;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state      <= IDLE;
            rgb_enable <= 3'b111;
        end else begin
            case (state)
                IDLE: begin
                    if (byte_valid) begin
                        case (opcode)
                            OP_RED_ON:      rgb_enable[0] <= 1'b1;
                            OP_RED_OFF:     rgb_enable[0] <= 1'b0;
                            OP_GREEN_ON:    rgb_enable[1] <= 1'b1;
                            OP_GREEN_OFF:   rgb_enable[1] <= 1'b0;
                            OP_BLUE_ON:     rgb_enable[2] <= 1'b1;
                            OP_BLUE_OFF:    rgb_enable[2] <= 1'b0;
                            OP_BRIGHT_LOAD: state <= READ_BRIGHTNESS;
                            OP_BLANK:       state <= BLANK;
                            OP_FILL:        state <= FILL;
                            OP_PIXEL:       state <= PIXEL;
                            // digits are decoded by the brightness register
                            default: begin
                            end
                        endcase
                    end
                end
                default: begin
                    if (engine_done) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* src/brightness_reg.sv */
/*
 * Brightness bit-plane enables. Digits toggle, clear or set planes;
 * with brightness_load high the next strobed byte is loaded directly.
 */
`timescale 1ns/10ps

module brightness_reg (
    input  logic                                          clk_in,
    input  logic                                          reset,
    input  logic                                          byte_valid,
    input  logic [7:0]                                    byte_data,
    input  logic                                          brightness_load,
    output logic [matrix_ctrl_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable
);

    import matrix_ctrl_pkg::*;

    cmd_opcode_e digit;

    assign digit = cmd_opcode_e'(byte_data);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            brightness_enable <= {BRIGHTNESS_LEVELS{1'b1}};
        end else if (byte_valid) begin
            if (brightness_load) begin
                brightness_enable <= byte_data[BRIGHTNESS_LEVELS-1:0];
            end else begin
                // digit n flips plane LEVELS-n, so 1 is the top plane
                case (digit)
                    OP_BRIGHT_1: brightness_enable[BRIGHTNESS_LEVELS-1] <=
                        ~brightness_enable[BRIGHTNESS_LEVELS-1];
                    OP_BRIGHT_2: brightness_enable[BRIGHTNESS_LEVELS-2] <=
                        ~brightness_enable[BRIGHTNESS_LEVELS-2];
                    OP_BRIGHT_3: brightness_enable[BRIGHTNESS_LEVELS-3] <=
                        ~brightness_enable[BRIGHTNESS_LEVELS-3];
                    OP_BRIGHT_4: brightness_enable[BRIGHTNESS_LEVELS-4] <=
                        ~brightness_enable[BRIGHTNESS_LEVELS-4];
                    OP_BRIGHT_5: brightness_enable[BRIGHTNESS_LEVELS-5] <=
                        ~brightness_enable[BRIGHTNESS_LEVELS-5];
                    OP_BRIGHT_6: brightness_enable[BRIGHTNESS_LEVELS-6] <=
                        ~brightness_enable[BRIGHTNESS_LEVELS-6];
                    OP_BRIGHT_CLEAR: brightness_enable <= {BRIGHTNESS_LEVELS{1'b0}};
                    OP_BRIGHT_SET:   brightness_enable <= {BRIGHTNESS_LEVELS{1'b1}};
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* src/panel_sweep.sv */
/*
 * Whole-panel write engine for blank and fill.
 * Fill first takes two colour bytes; both then write every RAM byte once, ascending.
 */
`timescale 1ns/10ps

module panel_sweep #(
    parameter int ROW_BITS = matrix_ctrl_pkg::ROW_BITS_DEF,
    parameter int COL_BITS = matrix_ctrl_pkg::COL_BITS_DEF
) (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       byte_valid,
    input  logic [7:0]                 byte_data,
    input  logic                       sweep_start,
    input  logic                       sweep_fill,
    output logic [ROW_BITS+COL_BITS:0] addr,
    output logic [7:0]                 data,
    output logic                       write_en,
    output logic                       done
);

    localparam int ADDR_BITS = ROW_BITS + COL_BITS + 1;

    logic                 capturing;
    logic                 color_idx;
    logic                 fill_mode;
    logic                 running;
    logic [ADDR_BITS-1:0] addr_count;
    logic [7:0]           color_hi;
    logic [7:0]           color_lo;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            capturing  <= 1'b0;
            color_idx  <= 1'b0;
            fill_mode  <= 1'b0;
            running    <= 1'b0;
            addr_count <= {ADDR_BITS{1'b0}};
        end else if (sweep_start) begin
            // blank runs at once, fill waits for its colour
            fill_mode  <= sweep_fill;
            capturing  <= sweep_fill;
            running    <= ~sweep_fill;
            color_idx  <= 1'b0;
            addr_count <= {ADDR_BITS{1'b0}};
        end else if (capturing && byte_valid) begin
            color_idx <= 1'b1;
            if (color_idx) begin
                capturing <= 1'b0;
                running   <= 1'b1;
            end
        end else if (running) begin
            addr_count <= addr_count + 1'b1;
            if (done) begin
                running <= 1'b0;
            end
        end
    end

    // colour bytes arrive high first
    always_ff @(posedge clk_in) begin
        if (capturing && byte_valid) begin
            if (color_idx) begin
                color_lo <= byte_data;
            end else begin
                color_hi <= byte_data;
            end
        end
    end

    assign addr     = addr_count;
    assign write_en = running;
    assign done     = running && (&addr_count);

    // odd address holds the high byte
    assign data = !fill_mode ? 8'd0 : (addr_count[0] ? color_hi : color_lo);

endmodule

/* src/pixel_write.sv */
/*
 * Single pixel write engine. Collects row, column and two colour bytes,
 * then writes the high byte at the odd address and the low byte at the even one.
 */
`timescale 1ns/10ps

module pixel_write #(
    parameter int ROW_BITS = matrix_ctrl_pkg::ROW_BITS_DEF,
    parameter int COL_BITS = matrix_ctrl_pkg::COL_BITS_DEF
) (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       byte_valid,
    input  logic [7:0]                 byte_data,
    input  logic                       pixel_start,
    output logic [ROW_BITS+COL_BITS:0] addr,
    output logic [7:0]                 data,
    output logic                       write_en,
    output logic                       done
);

    logic                collecting;
    logic [1:0]          arg_count;
    logic                writing;
    logic                low_phase;
    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] col;
    logic [7:0]          color_hi;
    logic [7:0]          color_lo;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            collecting <= 1'b0;
            arg_count  <= 2'd0;
            writing    <= 1'b0;
            low_phase  <= 1'b0;
        end else if (pixel_start) begin
            collecting <= 1'b1;
            arg_count  <= 2'd0;
        end else if (collecting && byte_valid) begin
            arg_count <= arg_count + 2'd1;
            if (arg_count == 2'd3) begin
                collecting <= 1'b0;
                writing    <= 1'b1;
                low_phase  <= 1'b0;
            end
        end else if (writing) begin
            // high byte then low byte on back to back cycles
            low_phase <= 1'b1;
            if (low_phase) begin
                writing <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (collecting && byte_valid) begin
            case (arg_count)
                2'd0: row <= byte_data[ROW_BITS-1:0];
                2'd1: col <= byte_data[COL_BITS-1:0];
                2'd2: color_hi <= byte_data;
                default: color_lo <= byte_data;
            endcase
        end
    end

    // inverted byte select puts the first colour byte at the odd address
    assign addr     = {row, col, ~low_phase};
    assign data     = low_phase ? color_lo : color_hi;
    assign write_en = writing;
    assign done     = writing && low_phase;

endmodule

/* src/matrix_ctrl_top.sv */
/*
 * Top level of the LED matrix command decoder.
 * Takes command bytes and drives colour enables, brightness planes and the frame RAM port.
 */
`timescale 1ns/10ps

module matrix_ctrl_top #(
    parameter int ROW_BITS = matrix_ctrl_pkg::ROW_BITS_DEF,
    parameter int COL_BITS = matrix_ctrl_pkg::COL_BITS_DEF
) (
    input  logic                                       clk_in,
    input  logic                                       reset,
    input  logic [7:0]                                 data_rx,
    input  logic                                       data_ready_n,
    output logic                                       ready_for_data,
    output logic                                       busy,
    output logic [2:0]                                 rgb_enable,
    output logic [matrix_ctrl_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic [ROW_BITS+COL_BITS:0]                 ram_address,
    output logic [7:0]                                 ram_data_out,
    output logic                                       ram_write_enable
);

    logic                       byte_valid;
    logic [7:0]                 byte_data;
    logic                       digit_valid;
    logic                       brightness_load;

    logic                       sweep_start;
    logic                       sweep_fill;
    logic [ROW_BITS+COL_BITS:0] sweep_addr;
    logic [7:0]                 sweep_data;
    logic                       sweep_write_en;
    logic                       sweep_done;

    logic                       pixel_start;
    logic [ROW_BITS+COL_BITS:0] pixel_addr;
    logic [7:0]                 pixel_data;
    logic                       pixel_write_en;
    logic                       pixel_done;

    cmd_dispatch #(
        .ROW_BITS(ROW_BITS),
        .COL_BITS(COL_BITS)
    ) cmd_dispatch_i (
        .clk_in          (clk_in),
        .reset           (reset),
        .data_rx         (data_rx),
        .data_ready_n    (data_ready_n),
        .sweep_addr      (sweep_addr),
        .sweep_data      (sweep_data),
        .sweep_write_en  (sweep_write_en),
        .sweep_done      (sweep_done),
        .pixel_addr      (pixel_addr),
        .pixel_data      (pixel_data),
        .pixel_write_en  (pixel_write_en),
        .pixel_done      (pixel_done),
        .ready_for_data  (ready_for_data),
        .busy            (busy),
        .byte_valid      (byte_valid),
        .byte_data       (byte_data),
        .digit_valid     (digit_valid),
        .rgb_enable      (rgb_enable),
        .brightness_load (brightness_load),
        .sweep_start     (sweep_start),
        .sweep_fill      (sweep_fill),
        .pixel_start     (pixel_start),
        .ram_address     (ram_address),
        .ram_data_out    (ram_data_out),
        .ram_write_enable(ram_write_enable)
    );

    // digit strobe only arrives while dispatch is idle or waiting for the T argument
    brightness_reg brightness_reg_i (
        .clk_in           (clk_in),
        .reset            (reset),
        .byte_valid       (digit_valid),
        .byte_data        (byte_data),
        .brightness_load  (brightness_load),
        .brightness_enable(brightness_enable)
    );

    panel_sweep #(
        .ROW_BITS(ROW_BITS),
        .COL_BITS(COL_BITS)
    ) panel_sweep_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .sweep_start(sweep_start),
        .sweep_fill (sweep_fill),
        .addr       (sweep_addr),
        .data       (sweep_data),
        .write_en   (sweep_write_en),
        .done       (sweep_done)
    );

    pixel_write #(
        .ROW_BITS(ROW_BITS),
        .COL_BITS(COL_BITS)
    ) pixel_write_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .pixel_start(pixel_start),
        .addr       (pixel_addr),
        .data       (pixel_data),
        .write_en   (pixel_write_en),
        .done       (pixel_done)
    );

endmodule

/* tests/matrix_ctrl_checker.sv */
/*
 * Watches the command decoder's byte port and outputs and compares them with a model
 * of the expected enables, handshake and RAM writes. Counts are read by the testbench top.
 */
`timescale 1ns/10ps

module matrix_ctrl_checker #(
    parameter int ROW_BITS = matrix_ctrl_pkg::ROW_BITS_DEF,
    parameter int COL_BITS = matrix_ctrl_pkg::COL_BITS_DEF
) (
    input  logic                                          clk_in,
    input  logic                                          reset,
    input  logic [7:0]                                    data_rx,
    input  logic                                          data_ready_n,
    input  logic                                          ready_for_data,
    input  logic                                          busy,
    input  logic [2:0]                                    rgb_enable,
    input  logic [matrix_ctrl_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable,
    input  logic [ROW_BITS+COL_BITS:0]                    ram_address,
    input  logic [7:0]                                    ram_data_out,
    input  logic                                          ram_write_enable,
    output int                                            mismatch_count,
    output int                                            error_count,
    output int                                            check_count,
    output int                                            pending_writes
);

    import matrix_ctrl_pkg::*;

    localparam int ADDR_BITS = ROW_BITS + COL_BITS + 1;
    localparam int RAM_BYTES = 1 << ADDR_BITS;

    ctrl_state_e                  m_state;
    logic [2:0]                   m_rgb;
    logic [BRIGHTNESS_LEVELS-1:0] m_bright;
    logic [7:0]                   args [4];
    int                           arg_count;
    // each entry is {address, data}
    logic [ADDR_BITS+7:0]         write_q [$];

    initial begin
        mismatch_count = 0;
        error_count    = 0;
        check_count    = 0;
        pending_writes = 0;
    end

    // high colour byte sits at the odd address of a pixel
    function automatic logic [ADDR_BITS-1:0] byte_address(input logic [7:0] row,
                                                          input logic [7:0] col,
                                                          input logic low_byte);
        return {row[ROW_BITS-1:0], col[COL_BITS-1:0], ~low_byte};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic queue_sweep(input logic [7:0] hi, input logic [7:0] lo);
        logic [ADDR_BITS-1:0] addr;
        for (int a = 0; a < RAM_BYTES; a++) begin
            addr = a;
            write_q.push_back({addr, addr[0] ? hi : lo});
        end
    endtask

    task automatic take_byte(input logic [7:0] value);
        cmd_opcode_e op;
        int          digit;
        op = cmd_opcode_e'(value);
        digit = value - 8'h30;
        case (m_state)
            IDLE: begin
                case (op)
                    OP_RED_ON:       m_rgb[0] = 1'b1;
                    OP_RED_OFF:      m_rgb[0] = 1'b0;
                    OP_GREEN_ON:     m_rgb[1] = 1'b1;
                    OP_GREEN_OFF:    m_rgb[1] = 1'b0;
                    OP_BLUE_ON:      m_rgb[2] = 1'b1;
                    OP_BLUE_OFF:     m_rgb[2] = 1'b0;
                    OP_BRIGHT_1, OP_BRIGHT_2, OP_BRIGHT_3,
                    OP_BRIGHT_4, OP_BRIGHT_5, OP_BRIGHT_6: begin
                        m_bright[BRIGHTNESS_LEVELS-digit] = ~m_bright[BRIGHTNESS_LEVELS-digit];
                    end
                    OP_BRIGHT_CLEAR: m_bright = '0;
                    OP_BRIGHT_SET:   m_bright = '1;
                    OP_BRIGHT_LOAD:  m_state = READ_BRIGHTNESS;
                    OP_BLANK: begin
                        m_state = BLANK;
                        queue_sweep(8'h00, 8'h00);
                    end
                    OP_FILL, OP_PIXEL: begin
                        m_state   = (op == OP_FILL) ? FILL : PIXEL;
                        arg_count = 0;
                    end
                    default: begin
                    end
                endcase
            end
            READ_BRIGHTNESS: begin
                m_bright = value[BRIGHTNESS_LEVELS-1:0];
                m_state  = IDLE;
            end
            FILL, PIXEL: begin
                if (arg_count < 4) begin
                    args[arg_count] = value;
                    arg_count++;
                end
                if (m_state == FILL && arg_count == 2) begin
                    queue_sweep(args[0], args[1]);
                end
                if (m_state == PIXEL && arg_count == 4) begin
                    write_q.push_back({byte_address(args[0], args[1], 1'b0), args[2]});
                    write_q.push_back({byte_address(args[0], args[1], 1'b1), args[3]});
                end
            end
            default: begin
                $display("byte %0h accepted at %0t while the panel blank was running",
                         value, $time);
                error_count++;
            end
        endcase
    endtask

    // inputs and outputs are settled mid-cycle, accepts and writes land on the next edge
    always @(negedge clk_in) begin
        logic [ADDR_BITS+7:0] expected;
        logic                 accept_now;
        logic                 expected_busy;
        accept_now = !data_ready_n && ready_for_data;
        if (reset) begin
            m_state   = IDLE;
            m_rgb     = 3'b111;
            m_bright  = '1;
            arg_count = 0;
            write_q.delete();
        end else begin
            expected_busy = (m_state != IDLE) && (write_q.size() != 1) &&
                            !(m_state == READ_BRIGHTNESS && accept_now);
            check_value("rgb_enable", rgb_enable, m_rgb);
            check_value("brightness_enable", brightness_enable, m_bright);
            check_value("busy", busy, expected_busy);
            check_value("ready_for_data", ready_for_data, write_q.size() == 0);
            if (ram_write_enable) begin
                if (write_q.size() == 0) begin
                    $display("unexpected RAM write at %0t to address %0h", $time, ram_address);
                    error_count++;
                end else begin
                    expected = write_q.pop_front();
                    check_value("ram_address", ram_address, expected[ADDR_BITS+7:8]);
                    check_value("ram_data_out", ram_data_out, expected[7:0]);
                    if (write_q.size() == 0) begin
                        m_state = IDLE;
                    end
                end
            end else if (write_q.size() != 0) begin
                $display("missing RAM write at %0t, %0d writes were still expected",
                         $time, write_q.size());
                error_count++;
                write_q.delete();
                m_state = IDLE;
            end
            if (accept_now) begin
                take_byte(data_rx);
            end
        end
        pending_writes = write_q.size();
    end

endmodule

/* tests/tb_matrix_ctrl.sv */
/*
 * Testbench for the LED matrix command decoder. Sends colour, brightness,
 * pixel, blank and fill commands; the checker module does the comparing.
 */
`timescale 1ns/10ps

module tb_matrix_ctrl;

    import matrix_ctrl_pkg::*;

    localparam int ROW_BITS       = ROW_BITS_DEF;
    localparam int COL_BITS       = COL_BITS_DEF;
    localparam int TIMEOUT_CYCLES = 12000;
    localparam int PIXEL_COUNT    = 16;

    logic                         clk_in;
    logic                         reset;
    logic [7:0]                   data_rx;
    logic                         data_ready_n;
    logic                         ready_for_data;
    logic                         busy;
    logic [2:0]                   rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [ROW_BITS+COL_BITS:0]   ram_address;
    logic [7:0]                   ram_data_out;
    logic                         ram_write_enable;

    int          mismatch_count;
    int          error_count;
    int          check_count;
    int          pending_writes;
    int          cycle_count = 0;
    logic [31:0] lfsr_state;

    matrix_ctrl_top #(
        .ROW_BITS(ROW_BITS),
        .COL_BITS(COL_BITS)
    ) matrix_ctrl_top_i (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .data_ready_n     (data_ready_n),
        .ready_for_data   (ready_for_data),
        .busy             (busy),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable)
    );

    matrix_ctrl_checker #(
        .ROW_BITS(ROW_BITS),
        .COL_BITS(COL_BITS)
    ) matrix_ctrl_checker_i (
        .clk_in           (clk_in),
        .reset            (reset),
        .data_rx          (data_rx),
        .data_ready_n     (data_ready_n),
        .ready_for_data   (ready_for_data),
        .busy             (busy),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable),
        .mismatch_count   (mismatch_count),
        .error_count      (error_count),
        .check_count      (check_count),
        .pending_writes   (pending_writes)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [7:0] value);
        value = 8'd0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    // called on a rising edge; strobe stays low until an edge finds the DUT ready
    task automatic send_byte(input logic [7:0] value);
        logic taken;
        taken = 1'b0;
        data_rx      <= value;
        data_ready_n <= 1'b0;
        while (!taken) begin
            @(negedge clk_in);
            taken = ready_for_data;
            @(posedge clk_in);
        end
        data_ready_n <= 1'b1;
    endtask

    task automatic send_text(input string text);
        for (int i = 0; i < text.len(); i++) begin
            send_byte(text[i]);
        end
    endtask

    task automatic send_spaced(input logic [7:0] value);
        logic [7:0] gap;
        draw_bits(2, gap);
        repeat (gap) @(posedge clk_in);
        send_byte(value);
    endtask

    initial begin
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] hi;
        logic [7:0] lo;
        reset        = 1'b1;
        data_rx      = 8'h00;
        data_ready_n = 1'b1;
        lfsr_state   = 32'hb264b1a9;
        repeat (3) @(posedge clk_in);
        reset <= 1'b0;
        repeat (2) @(posedge clk_in);

        send_text("rgbGRBgxA?");
        send_byte(8'hff);
        send_byte(8'h00);
        send_text("1234560135969");
        send_text("T");
        send_byte(8'h2a);
        send_text("T3T");
        send_byte(8'hc5);
        send_text("26");

        for (int n = 0; n < PIXEL_COUNT; n++) begin
            draw_bits(ROW_BITS, row);
            draw_bits(COL_BITS, col);
            draw_bits(8, hi);
            draw_bits(8, lo);
            send_text("P");
            send_spaced(row);
            send_spaced(col);
            send_spaced(hi);
            send_spaced(lo);
        end

        // F is held off by the blank sweep until it ends
        send_text("ZF");
        draw_bits(8, hi);
        draw_bits(8, lo);
        send_byte(hi);
        send_byte(lo);
        send_text("rG4b9");

        while (pending_writes != 0) begin
            @(posedge clk_in);
        end
        repeat (3) @(posedge clk_in);
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the command stream did not complete",
                     TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

endmodule

/* project.f */
src/matrix_ctrl_pkg.sv
src/cmd_dispatch.sv
src/brightness_reg.sv
src/panel_sweep.sv
src/pixel_write.sv
src/matrix_ctrl_top.sv
tests/matrix_ctrl_checker.sv
tests/tb_matrix_ctrl.sv
